/* vlog.f */
ppc_isa_pkg.sv
ppc_core_pkg.sv
instruction_decode.sv
dispatcher.sv
gp_reg_file.sv
reservation_station.sv
add_sub_unit.sv
log_unit.sv
write_back_arbiter.sv
ppc_core.sv
ppc_core_sva.sv
ppc_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ppc_core_tb -f vlog.f -o ppc_core_sim
./obj_dir/ppc_core_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* ppc_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ppc_core_tb import ppc_isa_pkg::*, ppc_core_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int N_DIRECTED = 6;
    localparam int N_UNSUPPORTED = 4;
    localparam int N_RANDOM = 60;
    localparam int N_BURST = 16;
    localparam int TOTAL_INSTR = N_DIRECTED + N_UNSUPPORTED + N_RANDOM + N_BURST;
    localparam int DRAIN_LIMIT = 200;
    localparam rs_id_t FIRST_ADD_SUB_ID = rs_id_t'(ADD_SUB_OFFSET);
    localparam rs_id_t FIRST_LOG_ID = rs_id_t'(LOG_OFFSET);
    localparam rs_id_t LAST_LOG_ID = rs_id_t'(LOG_OFFSET + RS_DEPTH - 1);

    typedef struct packed {
        gpr_addr_t rt;
        word_t result;
        logic is_log;
    } expect_t;

    logic clk = 1'b0;
    logic arst_n;
    logic instruction_valid;
    logic instruction_ready;
    instr_t instruction;
    logic wb_valid;
    wb_t wb;

    word_t model_regs [32];
    expect_t pending [$];
    int pending_count = 0;
    int accepted_count = 0;
    int supported_count = 0;
    int wb_count = 0;
    int mismatch_errors = 0;
    int other_errors = 0;
    logic in_burst = 1'b0;
    logic saw_backpressure = 1'b0;
    logic end_check = 1'b0;
    logic wb_hit = 1'b0;
    int hit_idx = 0;
    word_t rt_expected = '0;

    ppc_core DUT (
        .clk(clk),
        .arst_n(arst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    always #2 clk = ~clk;

    function automatic instr_t encode_d_form(opcode_t opc, gpr_addr_t d, gpr_addr_t a, imm_t imm);
        return {opc, d, a, imm};
    endfunction

    // Logical forms put the source in the first field and the target in the second
    function automatic instr_t encode_x_form(xo_t xo, gpr_addr_t s, gpr_addr_t a, gpr_addr_t b);
        return {OPC_X, s, a, b, xo, 1'b0};
    endfunction

    function automatic instr_t random_instruction();
        int kind;
        gpr_addr_t d;
        gpr_addr_t a;
        gpr_addr_t b;
        kind = int'($urandom_range(6, 0));
        d = gpr_addr_t'($urandom_range(7, 0));
        a = gpr_addr_t'($urandom_range(7, 0));
        b = gpr_addr_t'($urandom_range(7, 0));
        case (kind)
            0: return encode_d_form(OPC_ADDI, d, a, imm_t'($urandom));
            1: return encode_x_form(XO_ADD, d, a, b);
            2: return encode_x_form(XO_SUBF, d, a, b);
            3: return encode_x_form(XO_AND, a, d, b);
            4: return encode_x_form(XO_OR, a, d, b);
            5: return encode_x_form(XO_XOR, a, d, b);
            // mullw, not in the subset
            default: return encode_x_form(10'd235, d, a, b);
        endcase
    endfunction

    // In-order model of the subset
    task automatic predict_result(input instr_t word);
        logic [31:0] w;
        logic [5:0] opc;
        logic [9:0] xo;
        gpr_addr_t f6;
        gpr_addr_t f11;
        gpr_addr_t f16;
        word_t imm_ext;
        expect_t e;
        logic supported;
        w = word;
        opc = w[31:26];
        f6 = w[25:21];
        f11 = w[20:16];
        f16 = w[15:11];
        xo = w[10:1];
        imm_ext = {{16{w[15]}}, w[15:0]};
        supported = 1'b1;
        e.rt = f6;
        e.result = '0;
        e.is_log = 1'b0;
        if (opc == OPC_ADDI) begin
            e.result = ((f11 == '0) ? '0 : model_regs[f11]) + imm_ext;
        end else if (opc == OPC_X && xo == XO_ADD) begin
            e.result = model_regs[f11] + model_regs[f16];
        end else if (opc == OPC_X && xo == XO_SUBF) begin
            e.result = model_regs[f16] - model_regs[f11];
        end else if (opc == OPC_X && (xo == XO_AND || xo == XO_OR || xo == XO_XOR)) begin
            e.rt = f11;
            e.is_log = 1'b1;
            if (xo == XO_AND) begin
                e.result = model_regs[f6] & model_regs[f16];
            end else if (xo == XO_OR) begin
                e.result = model_regs[f6] | model_regs[f16];
            end else begin
                e.result = model_regs[f6] ^ model_regs[f16];
            end
        end else begin
            supported = 1'b0;
        end
        if (supported) begin
            model_regs[e.rt] = e.result;
            pending.push_back(e);
            supported_count++;
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_instruction(input instr_t word);
        logic taken;
        instruction_valid = 1'b1;
        instruction = word;
        taken = 1'b0;
        while (!taken) begin
            taken = instruction_ready;
            @(negedge clk);
        end
        instruction_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        instruction_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic print_summary();
        $display(
            "Errors: %0d mismatch, %0d other, %0d protocol; accepted %0d, %0d supported, %0d wb",
            mismatch_errors, other_errors, DUT.protocol_checks.failures,
            accepted_count, supported_count, wb_count);
    endtask

    // Bus is stable from here to the next rising edge
    always @(negedge clk) begin
        logic from_log;
        logic id_known;
        // Each unit owns the ids from its offset up
        from_log = (wb.rs_id >= FIRST_LOG_ID);
        id_known = (wb.rs_id >= FIRST_ADD_SUB_ID) && (wb.rs_id <= LAST_LOG_ID);
        wb_hit = 1'b0;
        hit_idx = 0;
        rt_expected = '0;
        for (int i = pending.size() - 1; i >= 0; i--) begin
            if (pending[i].rt == wb.rt && pending[i].is_log == from_log) begin
                rt_expected = pending[i].result;
                if (id_known && pending[i].result == wb.result) begin
                    wb_hit = 1'b1;
                    hit_idx = i;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            if (wb_valid) begin
                wb_count++;
                if (wb_hit) begin
                    pending.delete(hit_idx);
                end
            end
            if (instruction_valid && instruction_ready) begin
                accepted_count++;
                predict_result(instruction);
            end
            if (in_burst && !instruction_ready) begin
                saw_backpressure = 1'b1;
            end
            pending_count = pending.size();
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        accepted_count == 0 |-> !wb_valid && instruction_ready)
    else begin
        mismatch_errors++;
        $display("Mismatch before first instruction: wb_valid = %h, instruction_ready = %h",
                 $sampled(wb_valid), $sampled(instruction_ready));
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid && wb.rs_id < FIRST_LOG_ID |-> wb_hit)
    else begin
        mismatch_errors++;
        $display("Mismatch on add/sub wb: wb.rs_id = %h, wb.rt = %h, wb.result = %h, expected %h",
                 $sampled(wb.rs_id), $sampled(wb.rt), $sampled(wb.result),
                 $sampled(rt_expected));
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid && wb.rs_id >= FIRST_LOG_ID |-> wb_hit)
    else begin
        mismatch_errors++;
        $display("Mismatch on logical wb: wb.rs_id = %h, wb.rt = %h, wb.result = %h, expected %h",
                 $sampled(wb.rs_id), $sampled(wb.rt), $sampled(wb.result),
                 $sampled(rt_expected));
    end

    assert property (@(posedge clk) end_check |-> pending_count == 0)
    else begin
        other_errors++;
        $display("Accepted instructions never written back: %0d results still pending",
                 $sampled(pending_count));
    end

    assert property (@(posedge clk) end_check |-> wb_count == supported_count)
    else begin
        mismatch_errors++;
        $display("Mismatch: wb count = %h, expected %h", $sampled(wb_count),
                 $sampled(supported_count));
    end

    assert property (@(posedge clk) end_check |-> saw_backpressure)
    else begin
        other_errors++;
        $display("instruction_ready never went low during the dependent burst");
    end

    initial begin
        int waited;
        void'($urandom(32'h983c));
        arst_n = 1'b0;
        instruction_valid = 1'b0;
        instruction = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        idle_cycles(3);

        // Short dependent sequence across both units
        send_instruction(encode_d_form(OPC_ADDI, 5'd1, 5'd0, -16'sd5));
        send_instruction(encode_d_form(OPC_ADDI, 5'd2, 5'd0, 16'h1234));
        send_instruction(encode_x_form(XO_ADD, 5'd3, 5'd1, 5'd2));
        send_instruction(encode_x_form(XO_SUBF, 5'd4, 5'd3, 5'd1));
        send_instruction(encode_x_form(XO_AND, 5'd3, 5'd5, 5'd4));
        send_instruction(encode_d_form(OPC_ADDI, 5'd4, 5'd0, 16'd1));

        // mulli and addis
        send_instruction(encode_d_form(6'd7, 5'd2, 5'd1, 16'h0003));
        send_instruction(encode_d_form(6'd15, 5'd6, 5'd0, 16'h0001));

        for (int i = 0; i < N_RANDOM; i++) begin
            send_instruction(random_instruction());
            if ($urandom_range(5, 0) == 0) begin
                idle_cycles(1 + int'($urandom_range(2, 0)));
            end
        end

        // Back-to-back chain on r3 to fill the add/sub station
        in_burst = 1'b1;
        for (int i = 0; i < N_BURST - 4; i++) begin
            send_instruction(encode_x_form(XO_ADD, 5'd3, 5'd3, 5'd4));
        end
        for (int i = 0; i < 4; i++) begin
            send_instruction(encode_x_form(XO_XOR, 5'd3, 5'd5, 5'd5));
        end
        in_burst = 1'b0;

        // mullw and andc
        send_instruction(encode_x_form(10'd235, 5'd7, 5'd3, 5'd5));
        send_instruction(encode_x_form(10'd60, 5'd3, 5'd7, 5'd5));

        waited = 0;
        while (pending_count != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        // Room for a stray write-back
        idle_cycles(4);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);

        print_summary();
        if (mismatch_errors + other_errors + DUT.protocol_checks.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + 20 * TOTAL_INSTR) @(posedge clk);
        $display("Timeout: run did not finish, %0d results still pending", pending_count);
        print_summary();
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* ppc_core_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module ppc_core_sva import ppc_isa_pkg::*, ppc_core_pkg::*; (
    input logic clk,
    input logic arst_n,
    input logic instruction_valid,
    input logic instruction_ready,
    input instr_t instruction,
    input logic wb_valid,
    input wb_t wb
);

    int failures = 0;

    assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({wb_valid, instruction_ready}))
    else begin
        failures++;
        $error("wb_valid or instruction_ready is unknown");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> !$isunknown(wb))
    else begin
        failures++;
        $error("Write-back bus carries unknown bits while valid");
    end

    // Offered instruction held until accepted
    assert property (@(posedge clk) disable iff (!arst_n)
        instruction_valid && !instruction_ready |=> instruction_valid && $stable(instruction))
    else begin
        failures++;
        $error("Instruction withdrawn or changed before acceptance");
    end

endmodule

bind ppc_core ppc_core_sva protocol_checks (
    .clk(clk),
    .arst_n(arst_n),
    .instruction_valid(instruction_valid),
    .instruction_ready(instruction_ready),
    .instruction(instruction),
    .wb_valid(wb_valid),
    .wb(wb)
);

`default_nettype wire

/* ppc_core.sv */
`timescale 1ns/100ps
`default_nettype none

module ppc_core import ppc_isa_pkg::*, ppc_core_pkg::*; (
    input logic clk,
    input logic arst_n,

    input logic instruction_valid,
    output logic instruction_ready,
    input instr_t instruction,

    output logic wb_valid,
    output wb_t wb
);

    logic decode_valid;
    logic decode_ready;
    decode_t decode;

    gpr_addr_t read_addr_a;
    gpr_addr_t read_addr_b;
    operand_t read_a;
    operand_t read_b;
    logic update_enable;
    gpr_addr_t update_addr;
    rs_id_t update_rs_id;

    logic add_sub_valid;
    logic add_sub_ready;
    rs_id_t add_sub_id;
    logic log_valid;
    logic log_ready;
    rs_id_t log_id;
    unit_op_t op;
    gpr_addr_t rt;
    operand_t op1;
    operand_t op2;

    logic add_sub_out_valid;
    logic add_sub_out_ready;
    wb_t add_sub_result;
    logic log_out_valid;
    logic log_out_ready;
    wb_t log_result;

    instruction_decode instr_decode (
        .clk(clk),
        .arst_n(arst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .decode_valid(decode_valid),
        .decode_ready(decode_ready),
        .decode(decode)
    );

    dispatcher dispatch (.*);

    gp_reg_file gprs (
        .clk(clk),
        .arst_n(arst_n),
        .read_addr_a(read_addr_a),
        .read_addr_b(read_addr_b),
        .read_a(read_a),
        .read_b(read_b),
        .update_enable(update_enable),
        .update_addr(update_addr),
        .update_rs_id(update_rs_id),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    add_sub_unit add_sub (
        .clk(clk),
        .arst_n(arst_n),
        .input_valid(add_sub_valid),
        .input_ready(add_sub_ready),
        .op(op),
        .rt(rt),
        .op1(op1),
        .op2(op2),
        .id_taken(add_sub_id),
        .wb_valid(wb_valid),
        .wb(wb),
        .output_valid(add_sub_out_valid),
        .output_ready(add_sub_out_ready),
        .result(add_sub_result)
    );

    log_unit log (
        .clk(clk),
        .arst_n(arst_n),
        .input_valid(log_valid),
        .input_ready(log_ready),
        .op(op),
        .rt(rt),
        .op1(op1),
        .op2(op2),
        .id_taken(log_id),
        .wb_valid(wb_valid),
        .wb(wb),
        .output_valid(log_out_valid),
        .output_ready(log_out_ready),
        .result(log_result)
    );

    // Common bus also drives the top-level observation outputs
    write_back_arbiter arbiter (
        .add_sub_valid(add_sub_out_valid),
        .log_valid(log_out_valid),
        .add_sub_ready(add_sub_out_ready),
        .log_ready(log_out_ready),
        .add_sub_result(add_sub_result),
        .log_result(log_result),
        .wb_valid(wb_valid),
        .wb(wb)
    );

endmodule

`default_nettype wire

/* write_back_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module write_back_arbiter import ppc_core_pkg::*; (
    input logic add_sub_valid,
    input logic log_valid,
    output logic add_sub_ready,
    output logic log_ready,
    input wb_t add_sub_result,
    input wb_t log_result,

    output logic wb_valid,
    output wb_t wb
);

    logic add_sub_grant;
    logic log_grant;

    // Fixed priority, add/sub first
    assign add_sub_grant = add_sub_valid;
    assign log_grant = log_valid & ~add_sub_valid;

    assign add_sub_ready = 1'b1;
    assign log_ready = ~add_sub_valid;

    assign wb_valid = add_sub_grant | log_grant;

    always_comb begin
        if (add_sub_grant) begin
            wb = add_sub_result;
        end else begin
            wb = log_result;
        end
    end

endmodule

`default_nettype wire

/* log_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module log_unit import ppc_isa_pkg::*, ppc_core_pkg::*; (
    input logic clk,
    input logic arst_n,

    input logic input_valid,
    output logic input_ready,
    input unit_op_t op,
    input gpr_addr_t rt,
    input operand_t op1,
    input operand_t op2,
    output rs_id_t id_taken,

    input logic wb_valid,
    input wb_t wb,

    output logic output_valid,
    input logic output_ready,
    output wb_t result
);

    logic issue_valid;
    logic issue_ready;
    unit_op_t issue_op;
    gpr_addr_t issue_rt;
    rs_id_t issue_id;
    word_t issue_a;
    word_t issue_b;
    word_t logic_result;

    reservation_station #(
        .RS_OFFSET(LOG_OFFSET),
        .RS_DEPTH(RS_DEPTH)
    ) station (
        .clk(clk),
        .arst_n(arst_n),
        .input_valid(input_valid),
        .input_ready(input_ready),
        .op(op),
        .rt(rt),
        .op1(op1),
        .op2(op2),
        .id_taken(id_taken),
        .wb_valid(wb_valid),
        .wb(wb),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .issue_op(issue_op),
        .issue_rt(issue_rt),
        .issue_id(issue_id),
        .issue_a(issue_a),
        .issue_b(issue_b)
    );

    always_comb begin
        case (issue_op)
            OP_AND: logic_result = issue_a & issue_b;
            OP_OR: logic_result = issue_a | issue_b;
            default: logic_result = issue_a ^ issue_b;
        endcase
    end

    // Held while the arbiter serves the add/sub unit
    assign issue_ready = ~output_valid | output_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            output_valid <= 1'b0;
        end else if (issue_ready) begin
            output_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            result.rs_id <= issue_id;
            result.rt <= issue_rt;
            result.result <= logic_result;
        end
    end

endmodule

`default_nettype wire

/* add_sub_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module add_sub_unit import ppc_isa_pkg::*, ppc_core_pkg::*; (
    input logic clk,
    input logic arst_n,

    input logic input_valid,
    output logic input_ready,
    input unit_op_t op,
    input gpr_addr_t rt,
    input operand_t op1,
    input operand_t op2,
    output rs_id_t id_taken,

    input logic wb_valid,
    input wb_t wb,

    output logic output_valid,
    input logic output_ready,
    output wb_t result
);

    logic issue_valid;
    logic issue_ready;
    unit_op_t issue_op;
    gpr_addr_t issue_rt;
    rs_id_t issue_id;
    word_t issue_a;
    word_t issue_b;

    reservation_station #(
        .RS_OFFSET(ADD_SUB_OFFSET),
        .RS_DEPTH(RS_DEPTH)
    ) station (
        .clk(clk),
        .arst_n(arst_n),
        .input_valid(input_valid),
        .input_ready(input_ready),
        .op(op),
        .rt(rt),
        .op1(op1),
        .op2(op2),
        .id_taken(id_taken),
        .wb_valid(wb_valid),
        .wb(wb),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .issue_op(issue_op),
        .issue_rt(issue_rt),
        .issue_id(issue_id),
        .issue_a(issue_a),
        .issue_b(issue_b)
    );

    assign issue_ready = ~output_valid | output_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            output_valid <= 1'b0;
        end else if (issue_ready) begin
            output_valid <= issue_valid;
        end
    end

    // subf is rB minus rA
    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            result.rs_id <= issue_id;
            result.rt <= issue_rt;
            result.result <= (issue_op == OP_SUBF) ? issue_b - issue_a : issue_a + issue_b;
        end
    end

endmodule

`default_nettype wire

/* reservation_station.sv */
`timescale 1ns/100ps
`default_nettype none

module reservation_station import ppc_isa_pkg::*, ppc_core_pkg::*; #(
    parameter int RS_OFFSET = 1,
    parameter int RS_DEPTH = ppc_core_pkg::RS_DEPTH
) (
    input logic clk,
    input logic arst_n,

    input logic input_valid,
    output logic input_ready,
    input unit_op_t op,
    input gpr_addr_t rt,
    input operand_t op1,
    input operand_t op2,
    output rs_id_t id_taken,

    input logic wb_valid,
    input wb_t wb,

    output logic issue_valid,
    input logic issue_ready,
    output unit_op_t issue_op,
    output gpr_addr_t issue_rt,
    output rs_id_t issue_id,
    output word_t issue_a,
    output word_t issue_b
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    typedef struct packed {
        unit_op_t op;
        gpr_addr_t rt;
        operand_t a;
        operand_t b;
    } rs_entry_t;

    rs_entry_t entries [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy;
    logic [RS_DEPTH-1:0] issued;
    logic [RS_DEPTH-1:0] ready;
    // Bit j of row i set when entry j is older than entry i
    logic [RS_DEPTH-1:0] older_than [RS_DEPTH];
    logic [IDX_W-1:0] alloc_idx;
    logic [IDX_W-1:0] issue_idx;
    logic alloc;

    function automatic operand_t snoop(operand_t opnd, logic bus_valid, wb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.valid && bus_valid && bus.rs_id == opnd.rs_id) begin
            res.value = bus.result;
            res.valid = 1'b1;
        end
        return res;
    endfunction

    always_comb begin
        alloc_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_idx = i[IDX_W-1:0];
            end
        end
    end

    assign input_ready = ~&busy;
    assign alloc = input_valid & input_ready;
    assign id_taken = rs_id_t'(RS_OFFSET + int'(alloc_idx));

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready[i] = busy[i] & ~issued[i] & entries[i].a.valid & entries[i].b.valid;
        end
        issue_valid = 1'b0;
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (ready[i] && !(|(ready & older_than[i]))) begin
                issue_valid = 1'b1;
                issue_idx = i[IDX_W-1:0];
            end
        end
    end

    assign issue_op = entries[issue_idx].op;
    assign issue_rt = entries[issue_idx].rt;
    assign issue_id = rs_id_t'(RS_OFFSET + int'(issue_idx));
    assign issue_a = entries[issue_idx].a.value;
    assign issue_b = entries[issue_idx].b.value;

    // Slot stays allocated until its result leaves on the bus, so its id is never reused early
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
            issued <= '0;
            older_than <= '{default: '0};
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (issued[i] && wb_valid && wb.rs_id == rs_id_t'(RS_OFFSET + i)) begin
                    busy[i] <= 1'b0;
                end
            end
            if (issue_valid && issue_ready) begin
                issued[issue_idx] <= 1'b1;
            end
            if (alloc) begin
                busy[alloc_idx] <= 1'b1;
                issued[alloc_idx] <= 1'b0;
                for (int i = 0; i < RS_DEPTH; i++) begin
                    older_than[i][alloc_idx] <= 1'b0;
                end
                older_than[alloc_idx] <= busy;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entries[i].a <= snoop(entries[i].a, wb_valid, wb);
            entries[i].b <= snoop(entries[i].b, wb_valid, wb);
        end
        if (alloc) begin
            entries[alloc_idx] <= '{op: op, rt: rt,
                                    a: snoop(op1, wb_valid, wb),
                                    b: snoop(op2, wb_valid, wb)};
        end
    end

endmodule

`default_nettype wire

/* gp_reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module gp_reg_file import ppc_isa_pkg::*, ppc_core_pkg::*; (
    input logic clk,
    input logic arst_n,

    input gpr_addr_t read_addr_a,
    input gpr_addr_t read_addr_b,
    output operand_t read_a,
    output operand_t read_b,

    input logic update_enable,
    input gpr_addr_t update_addr,
    input rs_id_t update_rs_id,

    input logic wb_valid,
    input wb_t wb
);

    word_t values [NUM_GPRS];
    rs_id_t tags [NUM_GPRS];

    // Tagged register can still be read if its producer is on the bus now
    function automatic operand_t lookup(word_t value, rs_id_t tag, logic bus_valid, wb_t bus);
        operand_t res;
        res.value = value;
        res.valid = (tag == '0);
        res.rs_id = tag;
        if (!res.valid && bus_valid && bus.rs_id == tag) begin
            res.value = bus.result;
            res.valid = 1'b1;
        end
        return res;
    endfunction

    assign read_a = lookup(values[read_addr_a], tags[read_addr_a], wb_valid, wb);
    assign read_b = lookup(values[read_addr_b], tags[read_addr_b], wb_valid, wb);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_GPRS; i++) begin
                values[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            // A stale result of an overwritten producer is ignored
            if (wb_valid && tags[wb.rt] == wb.rs_id) begin
                values[wb.rt] <= wb.result;
                tags[wb.rt] <= '0;
            end
            if (update_enable) begin
                tags[update_addr] <= update_rs_id;
            end
        end
    end

endmodule

`default_nettype wire

/* dispatcher.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatcher import ppc_isa_pkg::*, ppc_core_pkg::*; (
    input logic decode_valid,
    output logic decode_ready,
    input decode_t decode,

    output gpr_addr_t read_addr_a,
    output gpr_addr_t read_addr_b,
    input operand_t read_a,
    input operand_t read_b,

    output logic update_enable,
    output gpr_addr_t update_addr,
    output rs_id_t update_rs_id,

    output logic add_sub_valid,
    output logic log_valid,
    input logic add_sub_ready,
    input logic log_ready,
    input rs_id_t add_sub_id,
    input rs_id_t log_id,

    output unit_op_t op,
    output gpr_addr_t rt,
    output operand_t op1,
    output operand_t op2
);

    always_comb begin
        case (decode.unit)
            UNIT_ADD_SUB: begin
                decode_ready = add_sub_ready;
                update_rs_id = add_sub_id;
            end
            UNIT_LOG: begin
                decode_ready = log_ready;
                update_rs_id = log_id;
            end
            // Unsupported encodings are dropped here
            default: begin
                decode_ready = 1'b1;
                update_rs_id = '0;
            end
        endcase
    end

    assign add_sub_valid = decode_valid & (decode.unit == UNIT_ADD_SUB);
    assign log_valid = decode_valid & (decode.unit == UNIT_LOG);

    assign read_addr_a = decode.ra;
    assign read_addr_b = decode.rb;
    assign op = decode.op;
    assign rt = decode.rt;

    always_comb begin
        op1 = read_a;
        op2 = read_b;
        if (decode.use_imm) begin
            op2.value = {{16{decode.imm[0]}}, decode.imm};
            op2.valid = 1'b1;
            op2.rs_id = '0;
            // addi with rA = 0 means a literal zero
            if (decode.ra == '0) begin
                op1.value = '0;
                op1.valid = 1'b1;
                op1.rs_id = '0;
            end
        end
    end

    assign update_enable = decode_valid & decode_ready & (decode.unit != UNIT_NONE);
    assign update_addr = decode.rt;

endmodule

`default_nettype wire

/* instruction_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module instruction_decode import ppc_isa_pkg::*, ppc_core_pkg::*; (
    input logic clk,
    input logic arst_n,

    input logic instruction_valid,
    output logic instruction_ready,
    input instr_t instruction,

    output logic decode_valid,
    input logic decode_ready,
    output decode_t decode
);

    opcode_t opcode;
    xo_t xo;
    decode_t next_decode;

    assign opcode = instruction[0:5];
    assign xo = instruction[21:30];

    assign instruction_ready = ~decode_valid | decode_ready;

    always_comb begin
        next_decode.unit = UNIT_NONE;
        next_decode.op = OP_ADD;
        next_decode.rt = instruction[6:10];
        next_decode.ra = instruction[11:15];
        next_decode.rb = instruction[16:20];
        next_decode.imm = instruction[16:31];
        next_decode.use_imm = 1'b0;

        if (opcode == OPC_ADDI) begin
            next_decode.unit = UNIT_ADD_SUB;
            next_decode.use_imm = 1'b1;
        end else if (opcode == OPC_X) begin
            case (xo)
                XO_ADD: next_decode.unit = UNIT_ADD_SUB;
                XO_SUBF: begin
                    next_decode.unit = UNIT_ADD_SUB;
                    next_decode.op = OP_SUBF;
                end
                XO_AND, XO_OR, XO_XOR: begin
                    // Logical forms write rA from rS and rB
                    next_decode.unit = UNIT_LOG;
                    next_decode.rt = instruction[11:15];
                    next_decode.ra = instruction[6:10];
                    next_decode.op = (xo == XO_AND) ? OP_AND :
                                     (xo == XO_OR) ? OP_OR : OP_XOR;
                end
                default: next_decode.unit = UNIT_NONE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decode_valid <= 1'b0;
        end else if (instruction_ready) begin
            decode_valid <= instruction_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instruction_valid && instruction_ready) begin
            decode <= next_decode;
        end
    end

endmodule

`default_nettype wire

/* ppc_core_pkg.sv */
`default_nettype none

package ppc_core_pkg;

    import ppc_isa_pkg::*;

    // Id 0 means the register has no pending producer
    localparam int RS_ID_WIDTH = 4;
    typedef logic [0:RS_ID_WIDTH-1] rs_id_t;

    localparam int RS_DEPTH = 4;
    localparam int ADD_SUB_OFFSET = 1;
    localparam int LOG_OFFSET = 5;

    typedef enum logic [2:0] {OP_ADD, OP_SUBF, OP_AND, OP_OR, OP_XOR} unit_op_t;
    typedef enum logic [1:0] {UNIT_NONE, UNIT_ADD_SUB, UNIT_LOG} unit_sel_t;

    typedef struct packed {
        unit_sel_t unit;
        unit_op_t op;
        gpr_addr_t ra;
        gpr_addr_t rb;
        gpr_addr_t rt;
        imm_t imm;
        logic use_imm;
    } decode_t;

    // Invalid operand carries the id of its producer instead of a value
    typedef struct packed {
        word_t value;
        logic valid;
        rs_id_t rs_id;
    } operand_t;

    typedef struct packed {
        rs_id_t rs_id;
        gpr_addr_t rt;
        word_t result;
    } wb_t;

endpackage

`default_nettype wire

/* ppc_isa_pkg.sv */
`default_nettype none

package ppc_isa_pkg;

    localparam int NUM_GPRS = 32;

    typedef logic [0:31] instr_t;
    typedef logic [0:4] gpr_addr_t;
    typedef logic [0:31] word_t;
    typedef logic signed [0:15] imm_t;
    typedef logic [0:5] opcode_t;
    typedef logic [0:9] xo_t;

    // Primary opcodes
    localparam opcode_t OPC_ADDI = 6'd14;
    localparam opcode_t OPC_X = 6'd31;

    // Extended opcodes, bits 21 to 30 of an X or XO form word
    localparam xo_t XO_ADD = 10'd266;
    localparam xo_t XO_SUBF = 10'd40;
    localparam xo_t XO_AND = 10'd28;
    localparam xo_t XO_OR = 10'd444;
    localparam xo_t XO_XOR = 10'd316;

endpackage

`default_nettype wire
